/* hdl/uart_cfg_pkg.sv */
// serial-line timing, FIFO sizing and serializer state types
`default_nettype none

package uart_cfg_pkg;

  // byte and FIFO geometry
  localparam int data_bits = 8;
  localparam int fifo_depth = 4;
  localparam int fifo_count_bits = 3;
  localparam int fifo_ptr_bits = $clog2(fifo_depth);

  // serial bit timing, in clock cycles
  localparam int clks_per_bit = 8;
  localparam int bit_count_bits = $clog2(clks_per_bit);
  localparam int bit_index_bits = $clog2(data_bits);

  typedef enum logic [1:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop
  } tx_state_e;

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_e;

endpackage

`default_nettype wire

/* hdl/uart_bus_pkg.sv */
// host command opcodes, response word layout and status bit positions
`default_nettype none

package uart_bus_pkg;

  localparam int word_bits = 32;

  typedef enum logic [1:0] {
    op_write_tx = 2'd0,
    op_read_rx = 2'd1,
    op_status = 2'd2
  } host_op_e;

  // response word: valid flag on top, byte in the low bits
  localparam int rsp_valid_bit = 31;

  // status word bits
  localparam int st_tx_full = 0;
  localparam int st_rx_empty = 1;
  localparam int st_tx_active = 2;
  localparam int st_rx_overrun = 3;

endpackage

`default_nettype wire

/* hdl/byte_stream_if.sv */
// valid/ready byte stream interface with src and snk modports
`timescale 1ns/1ps
`default_nettype none

interface byte_stream_if;
  import uart_cfg_pkg::*;

  logic valid;
  logic ready;
  logic [data_bits-1:0] data;

  modport src (
    output valid,
    output data,
    input ready
  );

  modport snk (
    input valid,
    input data,
    output ready
  );

endinterface

`default_nettype wire

/* hdl/uart_host_port.sv */
// host command decoder, FIFO push/pop control and response word register
`timescale 1ns/1ps
`default_nettype none

module uart_host_port (
  input wire logic clk,
  input wire logic rst,
  input wire logic cmd_valid,
  output logic cmd_ready,
  input uart_bus_pkg::host_op_e cmd_op,
  input wire logic [uart_bus_pkg::word_bits-1:0] cmd_wdata,
  output logic rsp_valid,
  input wire logic rsp_ready,
  output logic [uart_bus_pkg::word_bits-1:0] rsp_data,
  byte_stream_if.src tx_push,
  byte_stream_if.snk rx_pop,
  input wire logic tx_full,
  input wire logic rx_empty,
  input wire logic tx_active,
  input wire logic overrun_pulse
);
  import uart_cfg_pkg::*;
  import uart_bus_pkg::*;

  typedef enum logic {
    hs_ready,
    hs_respond
  } host_state_e;

  host_state_e state;
  logic accept;
  logic overrun_flag;
  logic [word_bits-1:0] rsp_next;
  logic [word_bits-1:0] rsp_reg;

  // writes wait here while the transmit FIFO has no room
  assign cmd_ready = (state == hs_ready) && !((cmd_op == op_write_tx) && !tx_push.ready);
  assign accept = cmd_valid && cmd_ready;

  assign tx_push.valid = accept && (cmd_op == op_write_tx);
  assign tx_push.data = cmd_wdata[data_bits-1:0];
  assign rx_pop.ready = accept && (cmd_op == op_read_rx);

  always_comb begin
    rsp_next = '0;
    case (cmd_op)
      op_write_tx: begin
        rsp_next[rsp_valid_bit] = 1'b1;
        rsp_next[data_bits-1:0] = cmd_wdata[data_bits-1:0];
      end
      op_read_rx: begin
        // empty receive FIFO leaves an all-zero word
        if (rx_pop.valid) begin
          rsp_next[rsp_valid_bit] = 1'b1;
          rsp_next[data_bits-1:0] = rx_pop.data;
        end
      end
      op_status: begin
        rsp_next[rsp_valid_bit] = 1'b1;
        rsp_next[st_tx_full] = tx_full;
        rsp_next[st_rx_empty] = rx_empty;
        rsp_next[st_tx_active] = tx_active;
        rsp_next[st_rx_overrun] = overrun_flag;
      end
      default: begin
        rsp_next = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= hs_ready;
      overrun_flag <= 1'b0;
    end else begin
      case (state)
        hs_ready: begin
          if (accept) begin
            state <= hs_respond;
          end
        end
        hs_respond: begin
          if (rsp_ready) begin
            state <= hs_ready;
          end
        end
        default: begin
          state <= hs_ready;
        end
      endcase
      // status read clears the flag, a drop in the same cycle keeps it set
      if (accept && (cmd_op == op_status)) begin
        overrun_flag <= overrun_pulse;
      end else if (overrun_pulse) begin
        overrun_flag <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rsp_reg <= rsp_next;
    end
  end

  assign rsp_valid = (state == hs_respond);
  assign rsp_data = rsp_reg;

endmodule

`default_nettype wire

/* hdl/byte_fifo.sv */
// four-entry circular byte FIFO with valid/ready on both sides
`timescale 1ns/1ps
`default_nettype none

module byte_fifo (
  input wire logic clk,
  input wire logic rst,
  byte_stream_if.snk in_side,
  byte_stream_if.src out_side,
  output logic full,
  output logic empty
);
  import uart_cfg_pkg::*;

  logic [data_bits-1:0] mem [fifo_depth];
  logic [fifo_ptr_bits-1:0] wr_ptr;
  logic [fifo_ptr_bits-1:0] rd_ptr;
  logic [fifo_count_bits-1:0] count;
  logic push;
  logic pop;

  assign full = (count == fifo_count_bits'(fifo_depth));
  assign empty = (count == '0);

  assign in_side.ready = !full;
  assign out_side.valid = !empty;
  assign out_side.data = mem[rd_ptr];

  assign push = in_side.valid && in_side.ready;
  assign pop = out_side.valid && out_side.ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_side.data;
    end
  end

  // pointers wrap naturally at the power-of-two depth
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/uart_transmitter.sv */
// 8N1 serializer driving txd from a byte stream
`timescale 1ns/1ps
`default_nettype none

module uart_transmitter (
  input wire logic clk,
  input wire logic rst,
  byte_stream_if.snk in_side,
  output logic txd,
  output logic tx_active
);
  import uart_cfg_pkg::*;

  tx_state_e state;
  logic [bit_count_bits-1:0] bit_cnt;
  logic [bit_index_bits-1:0] bit_idx;
  logic [data_bits-1:0] shift_reg;
  logic bit_done;
  logic take;

  assign bit_done = (bit_cnt == bit_count_bits'(clks_per_bit - 1));

  // taking the next byte in the last stop cycle keeps frames back to back
  assign in_side.ready = (state == tx_idle) || ((state == tx_stop) && bit_done);
  assign take = in_side.valid && in_side.ready;
  assign tx_active = (state != tx_idle);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= tx_idle;
      bit_cnt <= '0;
      bit_idx <= '0;
      txd <= 1'b1;
    end else if (take) begin
      state <= tx_start;
      bit_cnt <= '0;
      txd <= 1'b0;
    end else if (state != tx_idle) begin
      bit_cnt <= bit_done ? '0 : bit_cnt + 1'b1;
      case (state)
        tx_start: begin
          if (bit_done) begin
            state <= tx_data;
            bit_idx <= '0;
            txd <= shift_reg[0];
          end
        end
        tx_data: begin
          if (bit_done) begin
            if (bit_idx == bit_index_bits'(data_bits - 1)) begin
              state <= tx_stop;
              txd <= 1'b1;
            end else begin
              bit_idx <= bit_idx + 1'b1;
              txd <= shift_reg[1];
            end
          end
        end
        tx_stop: begin
          if (bit_done) begin
            state <= tx_idle;
          end
        end
        default: begin
          state <= tx_idle;
        end
      endcase
    end
  end

  // lsb first, shifted at each data bit boundary
  always_ff @(posedge clk) begin
    if (take) begin
      shift_reg <= in_side.data;
    end else if ((state == tx_data) && bit_done) begin
      shift_reg <= shift_reg >> 1;
    end
  end

endmodule

`default_nettype wire

/* hdl/uart_receiver.sv */
// 8N1 deserializer with rxd synchronizer, mid-bit sampling and drop detection
`timescale 1ns/1ps
`default_nettype none

module uart_receiver (
  input wire logic clk,
  input wire logic rst,
  input wire logic rxd,
  byte_stream_if.src out_side,
  output logic overrun_pulse
);
  import uart_cfg_pkg::*;

  rx_state_e state;
  logic rx_meta;
  logic rx_sync;
  logic rx_prev;
  logic [bit_count_bits-1:0] bit_cnt;
  logic [bit_index_bits-1:0] bit_idx;
  logic [data_bits-1:0] shift_reg;
  logic out_valid;
  logic bit_done;
  logic half_done;

  assign bit_done = (bit_cnt == bit_count_bits'(clks_per_bit - 1));
  assign half_done = (bit_cnt == bit_count_bits'(clks_per_bit / 2 - 1));

  // line idles high, so the flops come out of reset at 1
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rxd;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rx_idle;
      bit_cnt <= '0;
      bit_idx <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= 1'b0;
      case (state)
        rx_idle: begin
          bit_cnt <= '0;
          if (rx_prev && !rx_sync) begin
            state <= rx_start;
          end
        end
        rx_start: begin
          // recheck the start bit at its middle
          if (half_done) begin
            bit_cnt <= '0;
            bit_idx <= '0;
            state <= rx_sync ? rx_idle : rx_data;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        rx_data: begin
          bit_cnt <= bit_done ? '0 : bit_cnt + 1'b1;
          if (bit_done) begin
            if (bit_idx == bit_index_bits'(data_bits - 1)) begin
              state <= rx_stop;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end
        end
        rx_stop: begin
          bit_cnt <= bit_done ? '0 : bit_cnt + 1'b1;
          if (bit_done) begin
            // low stop sample is a framing error, byte discarded
            out_valid <= rx_sync;
            state <= rx_idle;
          end
        end
        default: begin
          state <= rx_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == rx_data) && bit_done) begin
      shift_reg <= {rx_sync, shift_reg[data_bits-1:1]};
    end
  end

  assign out_side.valid = out_valid;
  assign out_side.data = shift_reg;

  // byte is only offered once, a full FIFO loses it
  assign overrun_pulse = out_valid && !out_side.ready;

endmodule

`default_nettype wire

/* hdl/uart_top.sv */
// UART peripheral top level: host port, tx/rx FIFOs, transmitter and receiver
`timescale 1ns/1ps
`default_nettype none

module uart_top (
  input wire logic clk,
  input wire logic rst,
  input wire logic cmd_valid,
  output logic cmd_ready,
  input uart_bus_pkg::host_op_e cmd_op,
  input wire logic [uart_bus_pkg::word_bits-1:0] cmd_wdata,
  output logic rsp_valid,
  input wire logic rsp_ready,
  output logic [uart_bus_pkg::word_bits-1:0] rsp_data,
  output logic txd,
  input wire logic rxd
);

  logic tx_full;
  logic rx_empty;
  logic tx_active;
  logic overrun_pulse;

  // host to tx FIFO, tx FIFO to serializer, deserializer to rx FIFO, rx FIFO to host
  byte_stream_if tx_wr_bus ();
  byte_stream_if tx_rd_bus ();
  byte_stream_if rx_wr_bus ();
  byte_stream_if rx_rd_bus ();

  uart_host_port host_port (
    .clk(clk),
    .rst(rst),
    .cmd_valid(cmd_valid),
    .cmd_ready(cmd_ready),
    .cmd_op(cmd_op),
    .cmd_wdata(cmd_wdata),
    .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready),
    .rsp_data(rsp_data),
    .tx_push(tx_wr_bus.src),
    .rx_pop(rx_rd_bus.snk),
    .tx_full(tx_full),
    .rx_empty(rx_empty),
    .tx_active(tx_active),
    .overrun_pulse(overrun_pulse)
  );

  byte_fifo tx_fifo (
    .clk(clk),
    .rst(rst),
    .in_side(tx_wr_bus.snk),
    .out_side(tx_rd_bus.src),
    .full(tx_full),
    .empty()
  );

  byte_fifo rx_fifo (
    .clk(clk),
    .rst(rst),
    .in_side(rx_wr_bus.snk),
    .out_side(rx_rd_bus.src),
    .full(),
    .empty(rx_empty)
  );

  uart_transmitter transmitter (
    .clk(clk),
    .rst(rst),
    .in_side(tx_rd_bus.snk),
    .txd(txd),
    .tx_active(tx_active)
  );

  uart_receiver receiver (
    .clk(clk),
    .rst(rst),
    .rxd(rxd),
    .out_side(rx_wr_bus.src),
    .overrun_pulse(overrun_pulse)
  );

endmodule

`default_nettype wire

/* verification/uart_tb.sv */
// testbench for uart_top: clock, reset, loopback, txd monitor, host tasks, checks, watchdog
`timescale 1ns/1ps
`default_nettype none

module uart_tb;
  import uart_cfg_pkg::*;
  import uart_bus_pkg::*;

  localparam int clk_period_ns = 4;
  localparam int reset_cycles = 16;
  localparam int seed = 37075;
  localparam int loop_bytes = 4;
  localparam int burst_bytes = 6;
  localparam int overrun_bytes = 6;
  localparam int serial_frames = 2;
  localparam int total_frames = loop_bytes + burst_bytes + overrun_bytes + serial_frames;
  // ten bit times per frame and a margin of three
  localparam int timeout_ns = total_frames * 10 * clks_per_bit * clk_period_ns * 3;

  logic clk;
  logic rst;
  logic cmd_valid;
  logic cmd_ready;
  host_op_e cmd_op;
  logic [word_bits-1:0] cmd_wdata;
  logic rsp_valid;
  logic rsp_ready;
  logic [word_bits-1:0] rsp_data;
  logic txd;
  logic rxd;
  logic loopback;
  logic serial_line;

  // reference model state
  logic [word_bits-1:0] exp_rsp;
  logic [data_bits-1:0] sent_q [$];
  logic [data_bits-1:0] rx_model [$];
  logic model_overrun;
  int errors;
  int tests_passed;
  int tests_failed;

  assign rxd = loopback ? txd : serial_line;

  uart_top DUT (
    .clk(clk),
    .rst(rst),
    .cmd_valid(cmd_valid),
    .cmd_ready(cmd_ready),
    .cmd_op(cmd_op),
    .cmd_wdata(cmd_wdata),
    .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready),
    .rsp_data(rsp_data),
    .txd(txd),
    .rxd(rxd)
  );

  always #(clk_period_ns / 2) clk = ~clk;

  rsp_value_check: assert property (@(posedge clk) disable iff (rst)
    (rsp_valid && rsp_ready) |-> (rsp_data == exp_rsp))
    else begin
      errors++;
      $display("Fail at %0t: response 0x%08h, expected 0x%08h", $time, rsp_data, exp_rsp);
    end

  rsp_hold_check: assert property (@(posedge clk) disable iff (rst)
    (rsp_valid && !rsp_ready) |=> rsp_valid)
    else begin
      errors++;
      $display("response valid dropped before the host took it");
    end

  rsp_latency_check: assert property (@(posedge clk) disable iff (rst)
    (cmd_valid && cmd_ready) |=> rsp_valid)
    else begin
      errors++;
      $display("response valid did not rise in the cycle after the command was taken");
    end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // one host command with its response taken after a random stall
  task automatic do_cmd(input host_op_e op, input logic [word_bits-1:0] wdata,
                        input logic [word_bits-1:0] expected, output int stalls);
    int hold;
    stalls = 0;
    hold = $urandom % 3;
    exp_rsp = expected;
    cmd_op = op;
    cmd_wdata = wdata;
    cmd_valid = 1'b1;
    #1;
    while (!cmd_ready) begin
      @(posedge clk);
      #2;
      stalls++;
    end
    next_cycle();
    cmd_valid = 1'b0;
    while (!rsp_valid) begin
      next_cycle();
    end
    repeat (hold) next_cycle();
    rsp_ready = 1'b1;
    next_cycle();
    rsp_ready = 1'b0;
  endtask

  task automatic write_byte(input logic [data_bits-1:0] b, output int stalls);
    logic [word_bits-1:0] expected;
    logic [word_bits-1:0] wdata;
    expected = '0;
    expected[rsp_valid_bit] = 1'b1;
    expected[data_bits-1:0] = b;
    // upper command bits are noise the port must ignore
    wdata = $urandom;
    wdata[data_bits-1:0] = b;
    sent_q.push_back(b);
    do_cmd(op_write_tx, wdata, expected, stalls);
  endtask

  task automatic read_rx();
    logic [word_bits-1:0] expected;
    int stalls;
    expected = '0;
    if (rx_model.size() > 0) begin
      expected[rsp_valid_bit] = 1'b1;
      expected[data_bits-1:0] = rx_model.pop_front();
    end
    do_cmd(op_read_rx, '0, expected, stalls);
  endtask

  // tx bits follow sent_q and hold except in the last bits of a frame
  task automatic read_status();
    logic [word_bits-1:0] expected;
    int stalls;
    expected = '0;
    expected[rsp_valid_bit] = 1'b1;
    expected[st_tx_full] = (sent_q.size() > fifo_depth);
    expected[st_rx_empty] = (rx_model.size() == 0);
    expected[st_tx_active] = (sent_q.size() != 0);
    expected[st_rx_overrun] = model_overrun;
    do_cmd(op_status, '0, expected, stalls);
    model_overrun = 1'b0;
  endtask

  task automatic wait_tx_drained();
    while (sent_q.size() != 0) begin
      next_cycle();
    end
    // rest of the stop bit and the receiver push
    repeat (clks_per_bit) next_cycle();
  endtask

  task automatic send_serial_frame(input logic [data_bits-1:0] b, input logic stop_level);
    logic [data_bits+1:0] bits;
    bits = {stop_level, b, 1'b0};
    for (int i = 0; i < data_bits + 2; i++) begin
      serial_line = bits[i];
      repeat (clks_per_bit) next_cycle();
    end
    serial_line = 1'b1;
    repeat (2 * clks_per_bit) next_cycle();
  endtask

  task automatic finish_test(input int num, input string name, input int err_start);
    if (errors == err_start) begin
      tests_passed++;
      $display("test %0d passed: %s", num, name);
    end else begin
      tests_failed++;
      $display("test %0d failed: %s (%0d errors)", num, name, errors - err_start);
    end
  endtask

  // decodes each txd frame at mid-bit against the written bytes
  initial begin : txd_monitor
    logic [data_bits-1:0] frame_byte;
    logic [data_bits-1:0] want;
    forever begin
      @(negedge clk);
      if (!rst && txd == 1'b0) begin
        repeat (clks_per_bit / 2) @(negedge clk);
        assert (txd == 1'b0) else begin
          errors++;
          $display("Fail at %0t: start bit high at mid-bit", $time);
        end
        for (int i = 0; i < data_bits; i++) begin
          repeat (clks_per_bit) @(negedge clk);
          frame_byte[i] = txd;
        end
        repeat (clks_per_bit) @(negedge clk);
        assert (txd == 1'b1) else begin
          errors++;
          $display("Fail at %0t: stop bit low on txd", $time);
        end
        if (sent_q.size() == 0) begin
          errors++;
          $display("txd carried a frame that was never written");
        end else begin
          want = sent_q.pop_front();
          assert (frame_byte == want) else begin
            errors++;
            $display("Fail at %0t: txd frame 0x%02h, expected 0x%02h", $time, frame_byte, want);
          end
          if (loopback) begin
            if (rx_model.size() < fifo_depth) begin
              rx_model.push_back(want);
            end else begin
              model_overrun = 1'b1;
            end
          end
        end
      end
    end
  end

  initial begin : watchdog
    #(timeout_ns);
    $display("timeout: the run did not finish within %0d ns", timeout_ns);
    $display("Checks failed");
    $finish;
  end

  initial begin : stimulus
    int stalls;
    int burst_stalls;
    int err_start;
    logic [data_bits-1:0] b;
    clk = 1'b0;
    rst = 1'b1;
    cmd_valid = 1'b0;
    cmd_op = op_status;
    cmd_wdata = '0;
    rsp_ready = 1'b0;
    loopback = 1'b1;
    serial_line = 1'b1;
    exp_rsp = '0;
    model_overrun = 1'b0;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    void'($urandom(seed));
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b0;

    err_start = errors;
    assert (txd === 1'b1) else begin
      errors++;
      $display("Fail at %0t: txd is %b after reset", $time, txd);
    end
    assert (cmd_ready === 1'b1) else begin
      errors++;
      $display("Fail at %0t: cmd_ready is %b after reset", $time, cmd_ready);
    end
    assert (rsp_valid === 1'b0) else begin
      errors++;
      $display("Fail at %0t: rsp_valid is %b after reset", $time, rsp_valid);
    end
    read_status();
    finish_test(1, "reset state", err_start);

    err_start = errors;
    for (int i = 0; i < loop_bytes; i++) begin
      b = data_bits'($urandom);
      write_byte(b, stalls);
    end
    wait_tx_drained();
    for (int i = 0; i < loop_bytes; i++) begin
      read_rx();
    end
    finish_test(2, "loopback order", err_start);

    err_start = errors;
    read_rx();
    read_status();
    finish_test(3, "read from empty receive FIFO", err_start);

    err_start = errors;
    loopback = 1'b0;
    burst_stalls = 0;
    for (int i = 0; i < burst_bytes; i++) begin
      b = data_bits'($urandom);
      write_byte(b, stalls);
      if (stalls > burst_stalls) begin
        burst_stalls = stalls;
      end
    end
    assert (burst_stalls > 0) else begin
      errors++;
      $display("write burst never saw cmd_ready held low by a full transmit FIFO");
    end
    // transmit FIFO is full again and a frame is on txd
    read_status();
    wait_tx_drained();
    read_status();
    finish_test(4, "transmit back-pressure and frames", err_start);

    err_start = errors;
    loopback = 1'b1;
    for (int i = 0; i < overrun_bytes; i++) begin
      b = data_bits'($urandom);
      write_byte(b, stalls);
    end
    wait_tx_drained();
    read_status();
    read_status();
    for (int i = 0; i < fifo_depth; i++) begin
      read_rx();
    end
    read_rx();
    finish_test(5, "receive overrun", err_start);

    err_start = errors;
    loopback = 1'b0;
    b = data_bits'($urandom);
    send_serial_frame(b, 1'b0);
    read_rx();
    b = data_bits'($urandom);
    send_serial_frame(b, 1'b1);
    rx_model.push_back(b);
    read_rx();
    read_status();
    finish_test(6, "framing error then good frame", err_start);

    $display("summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
hdl/uart_cfg_pkg.sv
hdl/uart_bus_pkg.sv
hdl/byte_stream_if.sv
hdl/uart_host_port.sv
hdl/byte_fifo.sv
hdl/uart_transmitter.sv
hdl/uart_receiver.sv
hdl/uart_top.sv
verification/uart_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the UART testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module uart_tb \
  --Mdir obj_dir \
  -o uart_sim \
  -f sim.f

./obj_dir/uart_sim > sim.log 2>&1
cat sim.log

if grep -q "Checks failed" sim.log; then
  echo "simulation reported failures, see sim.log"
  exit 1
fi

echo "simulation finished without failures"
exit 0
